//--- logic/core_types_pkg.sv
package core_types_pkg;

    // ======================================
    // machine wide data types
    // ======================================

    typedef logic [31:0] word_t;      // register and operand value
    typedef logic [4:0]  reg_idx_t;   // register file index

    // station tag is the busy bus index plus one
    typedef logic [3:0]  rs_tag_t;

    // tag zero marks an operand whose value is already present
    localparam rs_tag_t NO_TAG = 4'd0;

    // ======================================
    // default station counts
    // ======================================

    // alu stations sit in the low busy bits and shift stations above them
    // the 4 bit tag allows at most 15 stations in total
    localparam int DEF_NUM_ALU_RS   = 3;
    localparam int DEF_NUM_SHIFT_RS = 2;

endpackage

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] instr_t;

    // ======================================
    // instruction field positions
    // ======================================
    localparam int RD_MSB     = 31;
    localparam int RD_LSB     = 27;
    localparam int RS1_MSB    = 26;
    localparam int RS1_LSB    = 22;
    localparam int RS2_MSB    = 21;
    localparam int RS2_LSB    = 17;
    localparam int F7_MSB     = 16;
    localparam int F7_LSB     = 10;
    localparam int F3_MSB     = 9;
    localparam int F3_LSB     = 7;
    localparam int OP_MSB     = 6;
    localparam int OP_LSB     = 0;
    localparam int IMM_MSB    = 21;   // 12 bit signed immediate
    localparam int IMM_LSB    = 10;
    localparam int SHAMT_MSB  = 14;   // shift amount of the immediate shifts
    localparam int SHAMT_LSB  = 10;
    localparam int SF7_MSB    = 21;   // funct7 of the immediate shifts
    localparam int SF7_LSB    = 15;

    // ======================================
    // opcodes and operations
    // ======================================
    localparam logic [6:0] OP_ALU_REG = 7'b0110011;
    localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub, sra and srai

    typedef enum logic [3:0] {
        ADDI, XORI, SLTI, SLTUI, ORI, ANDI,
        ADDR, SUBR, SLTR, SLTUR, XORR, ORR, ANDR
    } alu_op_t;

    typedef enum logic [2:0] {SLLI, SRLI, SRAI, SLLR, SRLR, SRAR} shift_op_t;

    typedef enum logic [1:0] {UNIT_NONE, UNIT_ALU, UNIT_SFT} unit_t;

endpackage

//--- logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import core_types_pkg::*, rv_isa_pkg::*; (
    input  instr_t      iq_data_i,
    output unit_t       unit_o,
    output alu_op_t     alu_op_o,
    output shift_op_t   shift_op_o,
    output logic        has_imm_o,
    output word_t       imm_o,
    output reg_idx_t    rd_o
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] sft_funct7;

    assign opcode     = iq_data_i[OP_MSB:OP_LSB];
    assign funct3     = iq_data_i[F3_MSB:F3_LSB];
    assign funct7     = iq_data_i[F7_MSB:F7_LSB];
    assign sft_funct7 = iq_data_i[SF7_MSB:SF7_LSB];
    assign rd_o       = iq_data_i[RD_MSB:RD_LSB];

    always_comb begin
        unit_o     = UNIT_NONE;   // branch, load, store and unknown
        alu_op_o   = ADDI;
        shift_op_o = SLLI;
        has_imm_o  = 1'b0;
        imm_o      = {{20{iq_data_i[IMM_MSB]}}, iq_data_i[IMM_MSB:IMM_LSB]};

        case (opcode)
            OP_ALU_REG: begin
                if (funct7 == 7'b0000000) begin
                    unit_o = UNIT_ALU;
                    case (funct3)
                        3'b000: alu_op_o = ADDR;
                        3'b010: alu_op_o = SLTR;
                        3'b011: alu_op_o = SLTUR;
                        3'b100: alu_op_o = XORR;
                        3'b110: alu_op_o = ORR;
                        3'b111: alu_op_o = ANDR;
                        3'b001: begin
                            unit_o     = UNIT_SFT;
                            shift_op_o = SLLR;
                        end
                        default: begin            // funct3 101
                            unit_o     = UNIT_SFT;
                            shift_op_o = SRLR;
                        end
                    endcase
                end else if (funct7 == FUNCT7_ALT && funct3 == 3'b000) begin
                    unit_o   = UNIT_ALU;
                    alu_op_o = SUBR;
                end else if (funct7 == FUNCT7_ALT && funct3 == 3'b101) begin
                    unit_o     = UNIT_SFT;
                    shift_op_o = SRAR;
                end
            end
            OP_ALU_IMM: begin
                has_imm_o = 1'b1;
                unit_o    = UNIT_ALU;
                case (funct3)
                    3'b000: alu_op_o = ADDI;
                    3'b010: alu_op_o = SLTI;
                    3'b011: alu_op_o = SLTUI;
                    3'b100: alu_op_o = XORI;
                    3'b110: alu_op_o = ORI;
                    3'b111: alu_op_o = ANDI;
                    3'b001: begin
                        unit_o = (sft_funct7 == 7'b0000000) ? UNIT_SFT : UNIT_NONE;
                        imm_o  = word_t'(iq_data_i[SHAMT_MSB:SHAMT_LSB]);
                    end
                    default: begin                // srli or srai
                        unit_o = (sft_funct7 == 7'b0000000 || sft_funct7 == FUNCT7_ALT) ?
                                 UNIT_SFT : UNIT_NONE;
                        shift_op_o = (sft_funct7 == FUNCT7_ALT) ? SRAI : SRLI;
                        imm_o      = word_t'(iq_data_i[SHAMT_MSB:SHAMT_LSB]);
                    end
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- logic/station_select.sv
`timescale 1ns/10ps

module station_select import core_types_pkg::*; #(
    parameter  int NUM_ALU_RS   = DEF_NUM_ALU_RS,
    parameter  int NUM_SHIFT_RS = DEF_NUM_SHIFT_RS,
    localparam int NUM_RS       = NUM_ALU_RS + NUM_SHIFT_RS
) (
    input  logic [NUM_RS-1:0]   busy_bus_i,
    output logic                alu_free_o,
    output logic                sft_free_o,
    output rs_tag_t             alu_tag_o,
    output rs_tag_t             sft_tag_o,
    output logic [NUM_RS-1:0]   alu_onehot_o,
    output logic [NUM_RS-1:0]   sft_onehot_o
);
    logic [NUM_RS-1:0] free_vec;

    // lowest set bit of free within lo..hi, as a one-hot vector
    function automatic logic [NUM_RS-1:0] lowest_free(input logic [NUM_RS-1:0] free,
                                                      input int lo, input int hi);
        logic [NUM_RS-1:0] hot;
        hot = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (free[i] && i >= lo && i <= hi) begin
                hot    = '0;
                hot[i] = 1'b1;
            end
        end
        return hot;
    endfunction

    function automatic rs_tag_t hot_to_tag(input logic [NUM_RS-1:0] hot);
        rs_tag_t tag;
        tag = NO_TAG;
        for (int i = 0; i < NUM_RS; i++) begin
            if (hot[i])
                tag = rs_tag_t'(i + 1);   // tag is index plus one
        end
        return tag;
    endfunction

    assign free_vec = ~busy_bus_i;

    assign alu_onehot_o = lowest_free(free_vec, 0, NUM_ALU_RS - 1);
    assign sft_onehot_o = lowest_free(free_vec, NUM_ALU_RS, NUM_RS - 1);

    assign alu_free_o = |alu_onehot_o;
    assign sft_free_o = |sft_onehot_o;
    assign alu_tag_o  = hot_to_tag(alu_onehot_o);
    assign sft_tag_o  = hot_to_tag(sft_onehot_o);

endmodule

//--- logic/operand_capture.sv
`timescale 1ns/10ps

module operand_capture import core_types_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        load_i,           // queue pop
    input  logic        has_imm_i,
    input  word_t       imm_i,
    input  word_t       reg_rd_data1_i,
    input  word_t       reg_rd_data2_i,
    input  rs_tag_t     reg_tag1_i,
    input  rs_tag_t     reg_tag2_i,
    input  reg_idx_t    src1_i,
    input  reg_idx_t    src2_i,
    input  logic        bypass_en_i,      // rename of the instruction issuing now
    input  reg_idx_t    bypass_rd_i,
    input  rs_tag_t     bypass_tag_i,
    input  rs_tag_t     cdb_tag_i,
    input  word_t       cdb_val_i,
    output word_t       rs_value1_o,
    output word_t       rs_value2_o,
    output rs_tag_t     rs_tag1_o,
    output rs_tag_t     rs_tag2_o
);
    typedef struct packed {
        word_t   val;
        rs_tag_t tag;
    } opnd_t;

    opnd_t held1, held2;    // holding register operands
    opnd_t out1, out2;      // cdb forwarded view
    opnd_t nxt1, nxt2;

    function automatic logic cdb_hit(input rs_tag_t tag);
        return (cdb_tag_i != NO_TAG) && (tag == cdb_tag_i);
    endfunction

    function automatic opnd_t fwd(input opnd_t cur);
        return cdb_hit(cur.tag) ? opnd_t'{cdb_val_i, NO_TAG} : cur;
    endfunction

    // cdb first, then rename bypass, then register file
    function automatic opnd_t capture(input word_t val, input rs_tag_t tag,
                                      input reg_idx_t src);
        opnd_t res;
        res = fwd(opnd_t'{val, tag});
        if (!cdb_hit(tag) && bypass_en_i && src == bypass_rd_i)
            res.tag = bypass_tag_i;
        return res;
    endfunction

    // ======================================
    // capture and snoop
    // ======================================
    always_comb begin
        out1 = fwd(held1);
        out2 = fwd(held2);  // immediates carry NO_TAG so never match
        if (load_i) begin
            nxt1 = capture(reg_rd_data1_i, reg_tag1_i, src1_i);
            nxt2 = has_imm_i ? opnd_t'{imm_i, NO_TAG} :
                               capture(reg_rd_data2_i, reg_tag2_i, src2_i);
        end else begin
            nxt1 = out1;    // keep snooping while held
            nxt2 = out2;
        end
    end

    always_ff @(posedge clk_i) begin
        held1.val <= nxt1.val;
        held2.val <= nxt2.val;
        if (reset_i) begin
            held1.tag <= NO_TAG;
            held2.tag <= NO_TAG;
        end else begin
            held1.tag <= nxt1.tag;
            held2.tag <= nxt2.tag;
        end
    end

    assign rs_value1_o = out1.val;
    assign rs_value2_o = out2.val;
    assign rs_tag1_o   = out1.tag;
    assign rs_tag2_o   = out2.tag;

endmodule

//--- logic/issue_control.sv
`timescale 1ns/10ps

module issue_control import core_types_pkg::*, rv_isa_pkg::*; #(
    parameter  int NUM_ALU_RS   = DEF_NUM_ALU_RS,
    parameter  int NUM_SHIFT_RS = DEF_NUM_SHIFT_RS,
    localparam int NUM_RS       = NUM_ALU_RS + NUM_SHIFT_RS
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                iq_empty_i,
    input  unit_t               unit_i,
    input  alu_op_t             alu_op_i,
    input  shift_op_t           shift_op_i,
    input  reg_idx_t            rd_i,
    input  logic                alu_free_i,
    input  logic                sft_free_i,
    input  rs_tag_t             alu_tag_i,
    input  rs_tag_t             sft_tag_i,
    input  logic [NUM_RS-1:0]   alu_onehot_i,
    input  logic [NUM_RS-1:0]   sft_onehot_i,
    output logic                iq_read_o,
    output logic [NUM_RS-1:0]   rs_write_en_o,
    output alu_op_t             alu_op_o,
    output shift_op_t           shift_op_o,
    output logic                reg_tag_wr_en_o,
    output reg_idx_t            reg_tag_wr_addr_o,
    output rs_tag_t             reg_tag_wr_tag_o
);
    logic       valid_q;    // holding register full
    unit_t      unit_q;
    logic       unit_free;
    logic       issue;

    assign unit_free = (unit_q == UNIT_ALU) ? alu_free_i :
                       (unit_q == UNIT_SFT) ? sft_free_i : 1'b0;
    assign issue     = valid_q && unit_free;

    // pop when the holding register is empty or drains this cycle
    assign iq_read_o = !reset_i && !iq_empty_i && (!valid_q || issue);

    always_ff @(posedge clk_i) begin
        if (reset_i)
            valid_q <= 1'b0;
        else if (iq_read_o)
            valid_q <= (unit_i != UNIT_NONE);   // drop unsupported encodings
        else if (issue)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (iq_read_o) begin
            unit_q            <= unit_i;
            alu_op_o          <= alu_op_i;
            shift_op_o        <= shift_op_i;
            reg_tag_wr_addr_o <= rd_i;
        end
    end

    // station write and destination rename in the same cycle
    assign rs_write_en_o    = !issue ? '0 :
                              (unit_q == UNIT_SFT) ? sft_onehot_i : alu_onehot_i;
    assign reg_tag_wr_en_o  = issue;
    assign reg_tag_wr_tag_o = (unit_q == UNIT_SFT) ? sft_tag_i : alu_tag_i;

endmodule

//--- logic/issue_top.sv
`timescale 1ns/10ps

module issue_top import core_types_pkg::*, rv_isa_pkg::*; #(
    parameter  int NUM_ALU_RS   = DEF_NUM_ALU_RS,
    parameter  int NUM_SHIFT_RS = DEF_NUM_SHIFT_RS,
    localparam int NUM_RS       = NUM_ALU_RS + NUM_SHIFT_RS
) (
    input  logic                clk_i,
    input  logic                reset_i,

    // ======================================
    // instruction queue, register file and status table
    input  instr_t              iq_data_i,
    input  logic                iq_empty_i,
    output logic                iq_read_o,
    output reg_idx_t            reg_rd_addr1_o,
    output reg_idx_t            reg_rd_addr2_o,
    input  word_t               reg_rd_data1_i,
    input  word_t               reg_rd_data2_i,
    input  rs_tag_t             reg_tag1_i,
    input  rs_tag_t             reg_tag2_i,
    output logic                reg_tag_wr_en_o,
    output reg_idx_t            reg_tag_wr_addr_o,
    output rs_tag_t             reg_tag_wr_tag_o,

    // ======================================
    // cdb and reservation stations
    input  rs_tag_t             cdb_tag_i,
    input  word_t               cdb_val_i,
    input  logic [NUM_RS-1:0]   busy_bus_i,
    output logic [NUM_RS-1:0]   rs_write_en_o,
    output word_t               rs_value1_o,
    output word_t               rs_value2_o,
    output rs_tag_t             rs_tag1_o,
    output rs_tag_t             rs_tag2_o,
    output alu_op_t             alu_op_o,
    output shift_op_t           shift_op_o
);
    unit_t              dec_unit;
    alu_op_t            dec_alu_op;
    shift_op_t          dec_shift_op;
    logic               dec_has_imm;
    word_t              dec_imm;
    reg_idx_t           dec_rd;
    logic               alu_free, sft_free;
    rs_tag_t            alu_tag, sft_tag;
    logic [NUM_RS-1:0]  alu_onehot, sft_onehot;

    // tag reads share these addresses
    assign reg_rd_addr1_o = iq_data_i[RS1_MSB:RS1_LSB];
    assign reg_rd_addr2_o = iq_data_i[RS2_MSB:RS2_LSB];

    instr_decoder u_decoder (
        .iq_data_i, .unit_o(dec_unit), .alu_op_o(dec_alu_op), .shift_op_o(dec_shift_op),
        .has_imm_o(dec_has_imm), .imm_o(dec_imm), .rd_o(dec_rd)
    );

    station_select #(.NUM_ALU_RS(NUM_ALU_RS), .NUM_SHIFT_RS(NUM_SHIFT_RS)) u_select (
        .busy_bus_i, .alu_free_o(alu_free), .sft_free_o(sft_free),
        .alu_tag_o(alu_tag), .sft_tag_o(sft_tag),
        .alu_onehot_o(alu_onehot), .sft_onehot_o(sft_onehot)
    );

    operand_capture u_capture (
        .clk_i, .reset_i, .load_i(iq_read_o), .has_imm_i(dec_has_imm), .imm_i(dec_imm),
        .reg_rd_data1_i, .reg_rd_data2_i, .reg_tag1_i, .reg_tag2_i,
        .src1_i(reg_rd_addr1_o), .src2_i(reg_rd_addr2_o),
        .bypass_en_i(reg_tag_wr_en_o), .bypass_rd_i(reg_tag_wr_addr_o),
        .bypass_tag_i(reg_tag_wr_tag_o), .cdb_tag_i, .cdb_val_i,
        .rs_value1_o, .rs_value2_o, .rs_tag1_o, .rs_tag2_o
    );

    issue_control #(.NUM_ALU_RS(NUM_ALU_RS), .NUM_SHIFT_RS(NUM_SHIFT_RS)) u_control (
        .clk_i, .reset_i, .iq_empty_i, .unit_i(dec_unit), .alu_op_i(dec_alu_op),
        .shift_op_i(dec_shift_op), .rd_i(dec_rd), .alu_free_i(alu_free),
        .sft_free_i(sft_free), .alu_tag_i(alu_tag), .sft_tag_i(sft_tag),
        .alu_onehot_i(alu_onehot), .sft_onehot_i(sft_onehot), .iq_read_o,
        .rs_write_en_o, .alu_op_o, .shift_op_o, .reg_tag_wr_en_o, .reg_tag_wr_addr_o,
        .reg_tag_wr_tag_o
    );

endmodule

//--- testbench/issue_tb.sv
`timescale 1ns/10ps

module issue_tb import core_types_pkg::*, rv_isa_pkg::*; ();

    localparam int NUM_ALU     = DEF_NUM_ALU_RS;
    localparam int NUM_RS      = DEF_NUM_ALU_RS + DEF_NUM_SHIFT_RS;
    localparam int NUM_INSTR   = 200;
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = (16 + 64 * NUM_INSTR) * CLK_NS;
    localparam logic [6:0] OTHER_OPS [4] = '{7'b1100011, 7'b0000011, 7'b0100011, 7'b1110111};

    logic clk_i, reset_i;
    instr_t iq_data_i;
    logic iq_empty_i, iq_read_o;
    reg_idx_t reg_rd_addr1_o, reg_rd_addr2_o, reg_tag_wr_addr_o;
    word_t reg_rd_data1_i, reg_rd_data2_i, cdb_val_i;
    rs_tag_t reg_tag1_i, reg_tag2_i, reg_tag_wr_tag_o, cdb_tag_i;
    logic reg_tag_wr_en_o;
    logic [NUM_RS-1:0] busy_bus_i, rs_write_en_o;
    word_t rs_value1_o, rs_value2_o;
    rs_tag_t rs_tag1_o, rs_tag2_o;
    alu_op_t alu_op_o;
    shift_op_t shift_op_o;

    // register file and status table models
    word_t regs [32];
    rs_tag_t tags [32];
    instr_t prog [$];       // queue contents, head first
    int issues, dropped;

    // model of the holding register
    logic m_valid;
    unit_t m_unit;
    alu_op_t m_alu;
    shift_op_t m_sft;
    reg_idx_t m_rd;
    word_t m_v1, m_v2;
    rs_tag_t m_t1, m_t2;

    // expected responses for the current cycle
    logic exp_read, exp_issue;
    logic [NUM_RS-1:0] exp_we;
    rs_tag_t exp_tag, exp_t1, exp_t2;
    word_t exp_v1, exp_v2;

    issue_top dut0 (.*);

    assign reg_rd_data1_i = regs[reg_rd_addr1_o];
    assign reg_rd_data2_i = regs[reg_rd_addr2_o];
    assign reg_tag1_i     = tags[reg_rd_addr1_o];
    assign reg_tag2_i     = tags[reg_rd_addr2_o];

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic logic on_cdb(input rs_tag_t tag);
        return cdb_tag_i != NO_TAG && tag == cdb_tag_i;
    endfunction

    // ========================================
    // stimulus and reference decode
    // ========================================
    function automatic instr_t make_instr();
        instr_t ins;
        logic [6:0] alt;
        int kind;
        ins = $urandom;
        ins[31:27] = reg_idx_t'($urandom_range(0, 7));   // few registers, many dependencies
        ins[26:22] = reg_idx_t'($urandom_range(0, 7));
        ins[21:17] = reg_idx_t'($urandom_range(0, 7));
        alt = ($urandom_range(0, 3) == 0) ? FUNCT7_ALT : 7'b0000000;
        kind = $urandom_range(0, 8);
        if (kind < 5) begin
            ins[6:0] = OP_ALU_REG;
            ins[16:10] = (kind == 4) ? 7'b0000001 : alt;
        end else if (kind < 8) begin
            ins[6:0] = OP_ALU_IMM;
            if (ins[9:7] == 3'b001 || ins[9:7] == 3'b101)
                ins[21:15] = alt;
        end else begin
            ins[6:0] = OTHER_OPS[$urandom_range(0, 3)];   // branch, load, store, unknown
        end
        return ins;
    endfunction

    function automatic void expect_decode(input instr_t ins, output unit_t u,
                                          output alu_op_t a, output shift_op_t s,
                                          output logic has_imm, output word_t immv);
        logic reg_form;
        logic [6:0] fsel;
        logic [2:0] f3;
        f3 = ins[9:7];
        reg_form = (ins[6:0] == OP_ALU_REG);
        has_imm = (ins[6:0] == OP_ALU_IMM);
        u = UNIT_NONE;
        a = ADDI;
        s = SLLI;
        immv = {{20{ins[21]}}, ins[21:10]};
        if (reg_form || has_imm) begin
            u = (f3 == 3'b001 || f3 == 3'b101) ? UNIT_SFT : UNIT_ALU;
            case (f3)
                3'b000: a = reg_form ? ADDR : ADDI;
                3'b010: a = reg_form ? SLTR : SLTI;
                3'b011: a = reg_form ? SLTUR : SLTUI;
                3'b100: a = reg_form ? XORR : XORI;
                3'b110: a = reg_form ? ORR : ORI;
                3'b111: a = reg_form ? ANDR : ANDI;
                3'b001: s = reg_form ? SLLR : SLLI;
                default: s = reg_form ? SRLR : SRLI;
            endcase
            if (has_imm && u == UNIT_SFT)
                immv = {27'd0, ins[14:10]};      // shift amount
            fsel = reg_form ? ins[16:10] : (u == UNIT_SFT ? ins[21:15] : 7'b0000000);
            if (reg_form && fsel == FUNCT7_ALT && f3 == 3'b000)
                a = SUBR;
            else if (fsel == FUNCT7_ALT && f3 == 3'b101)
                s = reg_form ? SRAR : SRAI;
            else if (fsel != 7'b0000000)
                u = UNIT_NONE;
        end
    endfunction

    // cdb first, then the rename of the issuing instruction, then the tables
    function automatic void capture_src(input reg_idx_t src, output word_t v,
                                        output rs_tag_t t);
        v = regs[src];
        t = tags[src];
        if (on_cdb(t)) begin
            v = cdb_val_i;
            t = NO_TAG;
        end else if (exp_issue && src == m_rd) begin
            t = exp_tag;
        end
    endfunction

    task automatic compute_expect();
        int lo, hi;
        lo = (m_unit == UNIT_SFT) ? NUM_ALU : 0;
        hi = (m_unit == UNIT_SFT) ? NUM_RS - 1 : NUM_ALU - 1;
        exp_we = '0;
        exp_tag = NO_TAG;
        for (int i = hi; i >= lo; i--) begin
            if (m_valid && !busy_bus_i[i]) begin
                exp_we = '0;
                exp_we[i] = 1'b1;
                exp_tag = rs_tag_t'(i + 1);
            end
        end
        exp_issue = |exp_we;
        exp_read = !iq_empty_i && (!m_valid || exp_issue);
        exp_v1 = on_cdb(m_t1) ? cdb_val_i : m_v1;
        exp_t1 = on_cdb(m_t1) ? NO_TAG : m_t1;
        exp_v2 = on_cdb(m_t2) ? cdb_val_i : m_v2;
        exp_t2 = on_cdb(m_t2) ? NO_TAG : m_t2;
    endtask

    task automatic step_model();
        unit_t u;
        alu_op_t a;
        shift_op_t s;
        logic has_imm;
        word_t immv, v1, v2;
        rs_tag_t t1, t2;
        if (exp_read) begin
            expect_decode(iq_data_i, u, a, s, has_imm, immv);
            capture_src(iq_data_i[26:22], v1, t1);
            capture_src(iq_data_i[21:17], v2, t2);
            if (has_imm) begin
                v2 = immv;
                t2 = NO_TAG;
            end
        end
        // result retires into the tables and frees its station
        if (cdb_tag_i != NO_TAG) begin
            busy_bus_i[int'(cdb_tag_i) - 1] = 1'b0;
            for (int r = 0; r < 32; r++) begin
                if (tags[r] == cdb_tag_i) begin
                    regs[r] = cdb_val_i;
                    tags[r] = NO_TAG;
                end
            end
        end
        if (exp_issue) begin
            busy_bus_i = busy_bus_i | exp_we;
            tags[m_rd] = exp_tag;           // rename
            issues++;
        end
        if (exp_read) begin
            m_valid = (u != UNIT_NONE);
            dropped += (u == UNIT_NONE) ? 1 : 0;
            m_unit = u;
            m_alu = a;
            m_sft = s;
            m_rd = iq_data_i[31:27];
            {m_v1, m_t1, m_v2, m_t2} = {v1, t1, v2, t2};
            void'(prog.pop_front());
        end else if (exp_issue) begin
            m_valid = 1'b0;
        end else begin
            {m_v1, m_t1, m_v2, m_t2} = {exp_v1, exp_t1, exp_v2, exp_t2};  // snooped while held
        end
    endtask

    task automatic drive_inputs();
        int idx, odds;
        odds = (prog.size() > NUM_INSTR / 2) ? 4 : 1;   // slow results first, stations fill
        iq_empty_i = (prog.size() == 0) || ($urandom_range(0, 5) == 0);
        if (prog.size() != 0)
            iq_data_i = prog[0];
        cdb_tag_i = NO_TAG;
        cdb_val_i = $urandom;
        if (busy_bus_i != '0 && $urandom_range(0, odds) == 0) begin
            idx = $urandom_range(0, NUM_RS - 1);
            while (!busy_bus_i[idx])
                idx = (idx + 1) % NUM_RS;
            cdb_tag_i = rs_tag_t'(idx + 1);
        end
    endtask

    // ========================================
    // checks
    // ========================================
    assert property (@(posedge clk_i) reset_i |-> !iq_read_o)
        else report_error("queue popped while in reset");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     !iq_empty_i |-> reg_rd_addr1_o == iq_data_i[26:22] &&
                                     reg_rd_addr2_o == iq_data_i[21:17])
        else report_error("register read address differs from the source fields");
    assert property (@(posedge clk_i) disable iff (reset_i) iq_read_o == exp_read)
        else report_error("iq_read_o does not follow the pop rule");
    assert property (@(posedge clk_i) disable iff (reset_i) rs_write_en_o == exp_we)
        else report_error("wrong station write enable");
    assert property (@(posedge clk_i) disable iff (reset_i) reg_tag_wr_en_o == exp_issue)
        else report_error("wrong rename enable");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     exp_issue |-> reg_tag_wr_addr_o == m_rd && reg_tag_wr_tag_o == exp_tag)
        else report_error("wrong rename address or tag");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     exp_issue |-> rs_tag1_o == exp_t1 && rs_tag2_o == exp_t2)
        else report_error("wrong operand tag");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     exp_issue && exp_t1 == NO_TAG |-> rs_value1_o == exp_v1)
        else report_error("wrong operand 1 value");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     exp_issue && exp_t2 == NO_TAG |-> rs_value2_o == exp_v2)
        else report_error("wrong operand 2 value");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     exp_issue && m_unit == UNIT_ALU |-> alu_op_o == m_alu)
        else report_error("wrong alu operation");
    assert property (@(posedge clk_i) disable iff (reset_i)
                     exp_issue && m_unit == UNIT_SFT |-> shift_op_o == m_sft)
        else report_error("wrong shift operation");

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the issue stage stopped making progress");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hf67b_4036));
        repeat (NUM_INSTR) prog.push_back(make_instr());
        foreach (regs[r]) begin
            regs[r] = $urandom;
            tags[r] = NO_TAG;
        end
        issues = 0;
        dropped = 0;
        m_valid = 1'b0;
        m_unit = UNIT_NONE;
        m_alu = ADDI;
        m_sft = SLLI;
        m_rd = '0;
        {m_v1, m_t1, m_v2, m_t2} = '0;
        {exp_read, exp_issue, exp_we, exp_tag} = '0;
        reset_i = 1'b1;
        iq_data_i = prog[0];
        iq_empty_i = 1'b0;      // head waiting while in reset
        busy_bus_i = '0;
        cdb_tag_i = NO_TAG;
        cdb_val_i = '0;
        repeat (16) @(posedge clk_i);
        #1 reset_i = 1'b0;
        compute_expect();
        while (prog.size() != 0 || m_valid) begin
            @(posedge clk_i);
            #1;
            step_model();
            drive_inputs();
            compute_expect();
        end
        $display("issued %0d, discarded %0d", issues, dropped);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- sim.f
logic/core_types_pkg.sv
logic/rv_isa_pkg.sv
logic/instr_decoder.sv
logic/station_select.sv
logic/operand_capture.sv
logic/issue_control.sv
logic/issue_top.sv
testbench/issue_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module issue_tb -f sim.f -o issue_sim
./obj_dir/issue_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
